/* verilog/memory_pkg.sv */
package memory_pkg;

    localparam int op_width = 3;
    localparam int size_width = 3;
    localparam int data_width = 32;
    localparam int strobe_width = data_width / 8;
    localparam int reg_addr_width = 5;

    // operation held by one issue lane.
    localparam logic [op_width-1:0] op_none = 3'd0;
    localparam logic [op_width-1:0] op_load = 3'd1;
    localparam logic [op_width-1:0] op_store = 3'd2;
    localparam logic [op_width-1:0] op_alu = 3'd3;
    localparam logic [op_width-1:0] op_fence = 3'd4;

    // access size, same encoding as the rv32 load/store funct3 field.
    localparam logic [size_width-1:0] size_byte = 3'b000;
    localparam logic [size_width-1:0] size_half = 3'b001;
    localparam logic [size_width-1:0] size_word = 3'b010;
    localparam logic [size_width-1:0] size_byte_u = 3'b100;
    localparam logic [size_width-1:0] size_half_u = 3'b101;

    // one memory word, whole or as four byte lanes (byte 0 is the low byte).
    typedef union packed {
        logic [data_width-1:0] word;
        logic [strobe_width-1:0][7:0] bytes;
    } word_data_u;

endpackage

/* verilog/mem_if.sv */
`timescale 1ns/10ps

interface mem_if import memory_pkg::*; #(
    parameter int addr_width = 12
) ();

    logic valid;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic [strobe_width-1:0] strb; // all zero for a read.
    word_data_u rdata;
    logic ready; // one cycle pulse, rdata valid with it.

    modport requester (
        output valid,
        output addr,
        output wdata,
        output strb,
        input rdata,
        input ready
    );

    modport responder (
        input valid,
        input addr,
        input wdata,
        input strb,
        output rdata,
        output ready
    );

endinterface

/* verilog/load_store_unit.sv */
`timescale 1ns/10ps

module load_store_unit import memory_pkg::*; (
    input logic [size_width-1:0] size,
    input logic [1:0] offset,
    input logic [data_width-1:0] store_data,
    input logic store,
    output logic [strobe_width-1:0] strb,
    output logic [data_width-1:0] wdata,
    input word_data_u rdata,
    output logic [data_width-1:0] load_data
);

    logic [7:0] load_byte;
    logic [15:0] load_half;

    // store side.
    always_comb begin
        case (size)
            size_byte, size_byte_u: begin
                wdata = {4{store_data[7:0]}};
                strb = strobe_width'(1) << offset;
            end
            size_half, size_half_u: begin
                wdata = {2{store_data[15:0]}};
                strb = offset[1] ? 4'b1100 : 4'b0011; // bit 0 ignored.
            end
            size_word: begin
                wdata = store_data;
                strb = 4'b1111;
            end
            default: begin
                wdata = store_data;
                strb = '0; // unknown size writes nothing.
            end
        endcase
        if (!store) begin
            strb = '0;
        end
    end

    // load side.
    always_comb begin
        load_byte = rdata.bytes[offset];
        if (offset[1]) begin
            load_half = {rdata.bytes[3], rdata.bytes[2]};
        end else begin
            load_half = {rdata.bytes[1], rdata.bytes[0]};
        end

        case (size)
            size_byte: load_data = {{24{load_byte[7]}}, load_byte};
            size_byte_u: load_data = {24'b0, load_byte};
            size_half: load_data = {{16{load_half[15]}}, load_half};
            size_half_u: load_data = {16'b0, load_half};
            default: load_data = rdata.word;
        endcase
    end

endmodule

/* verilog/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage import memory_pkg::*; #(
    parameter int addr_width = 12
) (
    input logic clock,
    input logic reset,
    input logic clear,
    input logic [op_width-1:0] issue_0_op,
    input logic [size_width-1:0] issue_0_size,
    input logic [addr_width-1:0] issue_0_address,
    input logic [data_width-1:0] issue_0_sdata,
    input logic [data_width-1:0] issue_0_result,
    input logic [reg_addr_width-1:0] issue_0_waddr,
    input logic [op_width-1:0] issue_1_op,
    input logic [size_width-1:0] issue_1_size,
    input logic [addr_width-1:0] issue_1_address,
    input logic [data_width-1:0] issue_1_sdata,
    input logic [data_width-1:0] issue_1_result,
    input logic [reg_addr_width-1:0] issue_1_waddr,
    output logic stall,
    output logic write_0_enable,
    output logic [reg_addr_width-1:0] write_0_addr,
    output logic [data_width-1:0] write_0_data,
    output logic write_1_enable,
    output logic [reg_addr_width-1:0] write_1_addr,
    output logic [data_width-1:0] write_1_data,
    mem_if.requester mem0,
    mem_if.requester mem1
);

    // lane registers.
    logic [op_width-1:0] op_r [2];
    logic [size_width-1:0] size_r [2];
    logic [addr_width-1:0] addr_r [2];
    logic [data_width-1:0] sdata_r [2];
    logic [data_width-1:0] result_r [2];
    logic [reg_addr_width-1:0] waddr_r [2];
    logic [1:0] pending_r; // request out on the bus.
    logic [1:0] done_r; // ready seen for this pair.
    logic [1:0] flush_r; // cleared request still in the memory.

    logic [op_width-1:0] in_op [2];
    logic [1:0] mem_ready;
    word_data_u mem_rdata [2];
    logic [strobe_width-1:0] strb [2];
    logic [data_width-1:0] wdata [2];
    logic [data_width-1:0] load_data [2];

    logic [1:0] is_mem;
    logic [1:0] waiting;
    logic [1:0] finished;
    logic retire;
    logic [1:0] write_enable;
    logic [data_width-1:0] write_data [2];

    assign in_op[0] = issue_0_op;
    assign in_op[1] = (issue_0_op == op_fence) ? op_none : issue_1_op; // fence squash.

    assign mem_ready = {mem1.ready, mem0.ready};
    assign mem_rdata[0] = mem0.rdata;
    assign mem_rdata[1] = mem1.rdata;

    for (genvar n = 0; n < 2; n++) begin : lane
        load_store_unit lsu (
            .size(size_r[n]),
            .offset(addr_r[n][1:0]),
            .store_data(sdata_r[n]),
            .store(op_r[n] == op_store),
            .strb(strb[n]),
            .wdata(wdata[n]),
            .rdata(mem_rdata[n]),
            .load_data(load_data[n])
        );
    end

    assign mem0.valid = pending_r[0];
    assign mem0.addr = addr_r[0];
    assign mem0.wdata = wdata[0];
    assign mem0.strb = strb[0];

    assign mem1.valid = pending_r[1];
    assign mem1.addr = addr_r[1];
    assign mem1.wdata = wdata[1];
    assign mem1.strb = strb[1];

    always_comb begin
        for (int n = 0; n < 2; n++) begin
            is_mem[n] = (op_r[n] == op_load) || (op_r[n] == op_store);
            waiting[n] = is_mem[n] & ~done_r[n];
            finished[n] = ~is_mem[n] | done_r[n] | mem_ready[n];
        end

        // stall covers the ready cycle itself.
        stall = (|waiting) | (|flush_r);

        // pairs without memory work retire right away.
        retire = (&finished) & (~(|is_mem) | (|(waiting & mem_ready)));

        for (int n = 0; n < 2; n++) begin
            write_enable[n] = retire & ~clear & (waddr_r[n] != '0)
                & ((op_r[n] == op_load) || (op_r[n] == op_alu));
            write_data[n] = (op_r[n] == op_load) ? load_data[n] : result_r[n];
        end
    end

    assign write_0_enable = write_enable[0];
    assign write_0_addr = waddr_r[0];
    assign write_0_data = write_data[0];
    assign write_1_enable = write_enable[1];
    assign write_1_addr = waddr_r[1];
    assign write_1_data = write_data[1];

    always_ff @(posedge clock) begin
        if (reset == 0) begin
            op_r[0] <= op_none;
            op_r[1] <= op_none;
            pending_r <= '0;
            done_r <= '0;
            flush_r <= '0;
        end else if (clear) begin
            op_r[0] <= op_none;
            op_r[1] <= op_none;
            pending_r <= '0;
            done_r <= '0;
            flush_r <= (flush_r | pending_r) & ~mem_ready; // let it drain.
        end else begin
            flush_r <= flush_r & ~mem_ready;
            if (!stall) begin
                for (int n = 0; n < 2; n++) begin
                    op_r[n] <= in_op[n];
                    pending_r[n] <= (in_op[n] == op_load) || (in_op[n] == op_store);
                end
                done_r <= '0;
            end else begin
                pending_r <= pending_r & ~mem_ready;
                done_r <= done_r | (pending_r & mem_ready);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            size_r[0] <= issue_0_size;
            addr_r[0] <= issue_0_address;
            sdata_r[0] <= issue_0_sdata;
            result_r[0] <= issue_0_result;
            waddr_r[0] <= issue_0_waddr;
            size_r[1] <= issue_1_size;
            addr_r[1] <= issue_1_address;
            sdata_r[1] <= issue_1_sdata;
            result_r[1] <= issue_1_result;
            waddr_r[1] <= issue_1_waddr;
        end
    end

endmodule

/* verilog/data_memory.sv */
`timescale 1ns/10ps

module data_memory import memory_pkg::*; #(
    parameter int addr_width = 12,
    parameter int wait_states = 2
) (
    input logic clock,
    input logic reset,
    mem_if.responder port0,
    mem_if.responder port1
);

    localparam int depth = 2 ** (addr_width - 2);
    localparam int count_width = $clog2(wait_states + 2);

    word_data_u mem [depth];

    logic [1:0] busy;
    logic [1:0] ready_r;
    logic [count_width-1:0] count [2];
    logic [addr_width-3:0] hold_index [2];
    logic [data_width-1:0] hold_wdata [2];
    logic [strobe_width-1:0] hold_strb [2];
    word_data_u rdata_r [2];

    logic [1:0] req_valid;
    logic [addr_width-1:0] req_addr [2];
    logic [data_width-1:0] req_wdata [2];
    logic [strobe_width-1:0] req_strb [2];

    logic [1:0] start;
    logic [1:0] respond;
    logic [addr_width-3:0] index [2];
    logic [data_width-1:0] wdata [2];
    logic [strobe_width-1:0] strb [2];
    logic [data_width-1:0] mask [2];
    logic [data_width-1:0] merged [2];

    assign req_valid = {port1.valid, port0.valid};
    assign req_addr[0] = port0.addr;
    assign req_addr[1] = port1.addr;
    assign req_wdata[0] = port0.wdata;
    assign req_wdata[1] = port1.wdata;
    assign req_strb[0] = port0.strb;
    assign req_strb[1] = port1.strb;

    assign port0.ready = ready_r[0];
    assign port0.rdata = rdata_r[0];
    assign port1.ready = ready_r[1];
    assign port1.rdata = rdata_r[1];

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            start[p] = req_valid[p] & ~busy[p] & ~ready_r[p];
            respond[p] = (start[p] | busy[p]) && (count[p] == count_width'(wait_states));
            // once started the request runs from its latched copy.
            index[p] = busy[p] ? hold_index[p] : req_addr[p][addr_width-1:2];
            wdata[p] = busy[p] ? hold_wdata[p] : req_wdata[p];
            strb[p] = busy[p] ? hold_strb[p] : req_strb[p];
            for (int b = 0; b < strobe_width; b++) begin
                mask[p][8*b +: 8] = {8{strb[p][b]}};
            end
        end
        merged[0] = (mem[index[0]].word & ~mask[0]) | (wdata[0] & mask[0]);
        // port 1 lands on top of port 0 when both hit one word.
        if (respond[0] && index[0] == index[1]) begin
            merged[1] = (merged[0] & ~mask[1]) | (wdata[1] & mask[1]);
        end else begin
            merged[1] = (mem[index[1]].word & ~mask[1]) | (wdata[1] & mask[1]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset == 0) begin
            busy <= '0;
            ready_r <= '0;
            count[0] <= '0;
            count[1] <= '0;
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                ready_r[p] <= respond[p];
                if (respond[p]) begin
                    busy[p] <= 1'b0;
                    count[p] <= '0;
                end else if (start[p] | busy[p]) begin
                    busy[p] <= 1'b1;
                    count[p] <= count[p] + 1'b1;
                end
            end
            if (respond[0] && strb[0] != '0) mem[index[0]].word <= merged[0];
            if (respond[1] && strb[1] != '0) mem[index[1]].word <= merged[1];
        end
    end

    always_ff @(posedge clock) begin
        for (int p = 0; p < 2; p++) begin
            if (start[p]) begin
                hold_index[p] <= req_addr[p][addr_width-1:2];
                hold_wdata[p] <= req_wdata[p];
                hold_strb[p] <= req_strb[p];
            end
            if (respond[p]) rdata_r[p] <= mem[index[p]]; // old word.
        end
    end

endmodule

/* verilog/memory_subsystem.sv */
`timescale 1ns/10ps

module memory_subsystem import memory_pkg::*; #(
    parameter int addr_width = 12,
    parameter int wait_states = 2
) (
    input logic clock,
    input logic reset,
    input logic clear,
    input logic [op_width-1:0] issue_0_op,
    input logic [size_width-1:0] issue_0_size,
    input logic [addr_width-1:0] issue_0_address,
    input logic [data_width-1:0] issue_0_sdata,
    input logic [data_width-1:0] issue_0_result,
    input logic [reg_addr_width-1:0] issue_0_waddr,
    input logic [op_width-1:0] issue_1_op,
    input logic [size_width-1:0] issue_1_size,
    input logic [addr_width-1:0] issue_1_address,
    input logic [data_width-1:0] issue_1_sdata,
    input logic [data_width-1:0] issue_1_result,
    input logic [reg_addr_width-1:0] issue_1_waddr,
    output logic stall,
    output logic write_0_enable,
    output logic [reg_addr_width-1:0] write_0_addr,
    output logic [data_width-1:0] write_0_data,
    output logic write_1_enable,
    output logic [reg_addr_width-1:0] write_1_addr,
    output logic [data_width-1:0] write_1_data
);

    // one bus per lane.
    mem_if #(.addr_width(addr_width)) mem_lane0 ();
    mem_if #(.addr_width(addr_width)) mem_lane1 ();

    memory_stage #(
        .addr_width(addr_width)
    ) stage (
        .clock(clock),
        .reset(reset),
        .clear(clear),
        .issue_0_op(issue_0_op),
        .issue_0_size(issue_0_size),
        .issue_0_address(issue_0_address),
        .issue_0_sdata(issue_0_sdata),
        .issue_0_result(issue_0_result),
        .issue_0_waddr(issue_0_waddr),
        .issue_1_op(issue_1_op),
        .issue_1_size(issue_1_size),
        .issue_1_address(issue_1_address),
        .issue_1_sdata(issue_1_sdata),
        .issue_1_result(issue_1_result),
        .issue_1_waddr(issue_1_waddr),
        .stall(stall),
        .write_0_enable(write_0_enable),
        .write_0_addr(write_0_addr),
        .write_0_data(write_0_data),
        .write_1_enable(write_1_enable),
        .write_1_addr(write_1_addr),
        .write_1_data(write_1_data),
        .mem0(mem_lane0.requester),
        .mem1(mem_lane1.requester)
    );

    data_memory #(
        .addr_width(addr_width),
        .wait_states(wait_states)
    ) data_mem (
        .clock(clock),
        .reset(reset),
        .port0(mem_lane0.responder),
        .port1(mem_lane1.responder)
    );

endmodule

/* verification/memory_subsystem_properties.sv */
`timescale 1ns/10ps

module memory_subsystem_properties import memory_pkg::*; #(
    parameter int addr_width = 12
) (
    input logic clock,
    input logic reset,
    input logic clear,
    input logic stall,
    input logic [1:0] valid,
    input logic [1:0] ready,
    input logic [addr_width-1:0] addr_0,
    input logic [addr_width-1:0] addr_1,
    input logic [data_width-1:0] wdata_0,
    input logic [data_width-1:0] wdata_1,
    input logic [strobe_width-1:0] strb_0,
    input logic [strobe_width-1:0] strb_1,
    input logic [1:0] write_enable,
    input logic [reg_addr_width-1:0] write_0_addr,
    input logic [reg_addr_width-1:0] write_1_addr
);

    int failures = 0; // number of failed assertions.

    // a request holds its fields until ready, unless clear drops it.
    request_0_held: assert property (@(posedge clock) disable iff (!reset)
        (valid[0] && !ready[0] && !clear) |=>
            (valid[0] && $stable(addr_0) && $stable(wdata_0) && $stable(strb_0)))
    else begin
        $error("lane 0 request changed before ready");
        failures++;
    end

    request_1_held: assert property (@(posedge clock) disable iff (!reset)
        (valid[1] && !ready[1] && !clear) |=>
            (valid[1] && $stable(addr_1) && $stable(wdata_1) && $stable(strb_1)))
    else begin
        $error("lane 1 request changed before ready");
        failures++;
    end

    stall_low_in_reset: assert property (@(posedge clock) !reset |=> !stall)
    else begin
        $error("stall high during or right after reset");
        failures++;
    end

    no_write_0_to_zero: assert property (@(posedge clock) disable iff (!reset)
        write_enable[0] |-> (write_0_addr != '0))
    else begin
        $error("lane 0 writes register 0");
        failures++;
    end

    no_write_1_to_zero: assert property (@(posedge clock) disable iff (!reset)
        write_enable[1] |-> (write_1_addr != '0))
    else begin
        $error("lane 1 writes register 0");
        failures++;
    end

    write_0_single: assert property (@(posedge clock) disable iff (!reset)
        write_enable[0] |=> !write_enable[0])
    else begin
        $error("lane 0 write enable longer than one cycle");
        failures++;
    end

    write_1_single: assert property (@(posedge clock) disable iff (!reset)
        write_enable[1] |=> !write_enable[1])
    else begin
        $error("lane 1 write enable longer than one cycle");
        failures++;
    end

endmodule

bind memory_stage memory_subsystem_properties #(
    .addr_width(addr_width)
) checks (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .stall(stall),
    .valid(pending_r),
    .ready(mem_ready),
    .addr_0(addr_r[0]),
    .addr_1(addr_r[1]),
    .wdata_0(wdata[0]),
    .wdata_1(wdata[1]),
    .strb_0(strb[0]),
    .strb_1(strb[1]),
    .write_enable(write_enable),
    .write_0_addr(write_0_addr),
    .write_1_addr(write_1_addr)
);

/* verification/tb_memory_subsystem.sv */
`timescale 1ns/10ps

module tb_memory_subsystem import memory_pkg::*; ();

    localparam int addr_width = 12;
    localparam int window = 32; // small byte window so that lanes collide.
    localparam int pair_timeout = 20;
    localparam int random_pairs = 300;

    logic clock;
    logic reset;
    logic clear;
    logic [op_width-1:0] lane_op [2];
    logic [size_width-1:0] lane_size [2];
    logic [addr_width-1:0] lane_address [2];
    logic [data_width-1:0] lane_sdata [2];
    logic [data_width-1:0] lane_result [2];
    logic [reg_addr_width-1:0] lane_waddr [2];
    logic stall;
    logic [1:0] write_enable;
    logic [reg_addr_width-1:0] write_addr [2];
    logic [data_width-1:0] write_data [2];

    logic [31:0] rng_state = 32'ha036;
    logic [7:0] shadow [window];
    logic [1:0] expect_write;
    logic [1:0] write_seen;
    logic [reg_addr_width-1:0] expect_waddr [2];
    logic [data_width-1:0] expect_data [2];

    memory_subsystem DUT (
        .clock(clock),
        .reset(reset),
        .clear(clear),
        .issue_0_op(lane_op[0]),
        .issue_0_size(lane_size[0]),
        .issue_0_address(lane_address[0]),
        .issue_0_sdata(lane_sdata[0]),
        .issue_0_result(lane_result[0]),
        .issue_0_waddr(lane_waddr[0]),
        .issue_1_op(lane_op[1]),
        .issue_1_size(lane_size[1]),
        .issue_1_address(lane_address[1]),
        .issue_1_sdata(lane_sdata[1]),
        .issue_1_result(lane_result[1]),
        .issue_1_waddr(lane_waddr[1]),
        .stall(stall),
        .write_0_enable(write_enable[0]),
        .write_0_addr(write_addr[0]),
        .write_0_data(write_data[0]),
        .write_1_enable(write_enable[1]),
        .write_1_addr(write_addr[1]),
        .write_1_data(write_data[1])
    );

    always #10 clock = ~clock;

    always @(negedge clock) begin
        if (DUT.stage.checks.failures != 0) begin
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // little endian; half ignores address bit 0, word ignores bits 1:0.
    function automatic logic [31:0] expected_load(logic [addr_width-1:0] address,
                                                  logic [size_width-1:0] size);
        int a;
        int half;
        logic [7:0] b;
        logic [15:0] h;
        a = int'(address);
        half = a - (a % 4) + (a & 2);
        b = shadow[a];
        h = {shadow[half+1], shadow[half]};
        case (size)
            size_byte: return {{24{b[7]}}, b};
            size_byte_u: return {24'h0, b};
            size_half: return {{16{h[15]}}, h};
            size_half_u: return {16'h0, h};
            default: return {shadow[half-(a&2)+3], shadow[half-(a&2)+2],
                             shadow[half-(a&2)+1], shadow[half-(a&2)]};
        endcase
    endfunction

    function automatic void apply_store(logic [addr_width-1:0] address,
                                        logic [size_width-1:0] size, logic [31:0] data);
        int a;
        int base;
        a = int'(address);
        base = a - (a % 4);
        case (size)
            size_byte, size_byte_u: shadow[a] = data[7:0];
            size_half, size_half_u: begin
                shadow[base + (a & 2)] = data[7:0];
                shadow[base + (a & 2) + 1] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    shadow[base + i] = data[8*i +: 8];
                end
            end
        endcase
    endfunction

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic drive_slot();
        @(posedge clock);
        #1;
    endtask

    task automatic set_lane(int n, logic [op_width-1:0] op, logic [size_width-1:0] size,
                            logic [addr_width-1:0] address, logic [31:0] data,
                            logic [reg_addr_width-1:0] waddr);
        lane_op[n] = op;
        lane_size[n] = size;
        lane_address[n] = address;
        lane_sdata[n] = data;
        lane_result[n] = ~data;
        lane_waddr[n] = waddr;
    endtask

    task automatic random_lane(int n);
        logic [31:0] r;
        logic [op_width-1:0] op;
        logic [size_width-1:0] size;
        logic [reg_addr_width-1:0] waddr;
        r = next_random();
        case (r[31:29])
            3'd0, 3'd1, 3'd7: op = op_load;
            3'd2, 3'd3: op = op_store;
            3'd4: op = op_alu;
            3'd5: op = op_none;
            default: op = op_fence;
        endcase
        case (r[28:26])
            3'd0: size = size_byte;
            3'd1: size = size_half;
            3'd3: size = size_byte_u;
            3'd4: size = size_half_u;
            default: size = size_word;
        endcase
        waddr = (r[7:5] == 3'd0) ? '0 : r[4:0]; // register 0 now and then.
        set_lane(n, op, size, 12'(r[20:16]), next_random(), waddr);
    endtask

    task automatic check_writes();
        for (int n = 0; n < 2; n++) begin
            if (write_enable[n]) begin
                assert (expect_write[n] && !write_seen[n])
                    else report_failure($sformatf("unexpected write on lane %0d", n));
                assert (write_addr[n] == expect_waddr[n])
                    else report_mismatch($sformatf("write_%0d_addr", n),
                                         32'(expect_waddr[n]), 32'(write_addr[n]));
                assert (write_data[n] == expect_data[n])
                    else report_mismatch($sformatf("write_%0d_data", n),
                                         expect_data[n], write_data[n]);
                write_seen[n] = 1'b1;
            end
        end
    endtask

    // called at the drive point with both lanes set; flush clears the pair mid-stall.
    task automatic run_pair(logic flush);
        logic [op_width-1:0] op [2];
        logic mem_pair;
        int cycles;
        op[0] = lane_op[0];
        op[1] = (lane_op[0] == op_fence) ? op_none : lane_op[1];
        mem_pair = 1'b0;
        for (int n = 0; n < 2; n++) begin
            expect_write[n] = !flush && (op[n] == op_load || op[n] == op_alu)
                && lane_waddr[n] != '0;
            expect_waddr[n] = lane_waddr[n];
            expect_data[n] = (op[n] == op_load) ?
                expected_load(lane_address[n], lane_size[n]) : lane_result[n];
            mem_pair |= (op[n] == op_load || op[n] == op_store);
        end
        for (int n = 0; n < 2; n++) begin
            if (op[n] == op_store) apply_store(lane_address[n], lane_size[n], lane_sdata[n]);
        end
        write_seen = '0;
        @(negedge clock);
        assert (!stall) else report_mismatch("stall", 32'h0, 32'(stall));
        drive_slot();
        lane_op[0] = op_none;
        lane_op[1] = op_none;
        @(negedge clock);
        assert (stall == mem_pair) else report_mismatch("stall", 32'(mem_pair), 32'(stall));
        if (flush) begin
            check_writes();
            drive_slot();
            clear = 1'b1;
            @(negedge clock);
            check_writes();
            drive_slot();
            clear = 1'b0;
            @(negedge clock);
        end
        cycles = 0;
        while (stall) begin
            check_writes();
            cycles++;
            if (cycles > pair_timeout) report_failure("stall stayed high past the timeout");
            @(negedge clock);
        end
        check_writes();
        for (int n = 0; n < 2; n++) begin
            assert (write_seen[n] == expect_write[n])
                else report_failure($sformatf("missing write on lane %0d", n));
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        clear = 1'b0;
        for (int n = 0; n < 2; n++) begin
            set_lane(n, op_none, size_word, '0, '0, '0);
        end
        for (int i = 0; i < window; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b1;

        // one known word, then every load size and alignment.
        drive_slot();
        set_lane(0, op_store, size_word, 12'd0, 32'h80f1_7f92, 5'd0);
        set_lane(1, op_alu, size_word, 12'd0, 32'h0000_1234, 5'd3);
        run_pair(1'b0);
        for (int offset = 0; offset < 4; offset++) begin
            drive_slot();
            set_lane(0, op_load, size_byte, 12'(offset), 32'h0, 5'd1);
            set_lane(1, op_load, size_byte_u, 12'(offset), 32'h0, 5'd2);
            run_pair(1'b0);
            drive_slot();
            set_lane(0, op_load, size_half, 12'(offset), 32'h0, 5'd3);
            set_lane(1, op_load, size_half_u, 12'(offset), 32'h0, 5'd4);
            run_pair(1'b0);
            drive_slot();
            set_lane(0, op_load, size_word, 12'(offset), 32'h0, 5'd5);
            set_lane(1, op_alu, size_word, 12'(offset), 32'h1357_9bdf, 5'd6);
            run_pair(1'b0);
        end

        // partial stores, then both lanes into one word.
        drive_slot();
        set_lane(0, op_store, size_word, 12'd4, 32'h1122_3344, 5'd0);
        set_lane(1, op_store, size_word, 12'd8, 32'h5566_7788, 5'd0);
        run_pair(1'b0);
        drive_slot();
        set_lane(0, op_store, size_byte, 12'd5, 32'h0000_00aa, 5'd0);
        set_lane(1, op_store, size_half_u, 12'd7, 32'h0000_bbcc, 5'd0);
        run_pair(1'b0);
        drive_slot();
        set_lane(0, op_store, size_word, 12'd8, 32'hdead_beef, 5'd0);
        set_lane(1, op_store, size_byte, 12'd9, 32'h0000_00ee, 5'd0);
        run_pair(1'b0);
        drive_slot();
        set_lane(0, op_load, size_word, 12'd4, 32'h0, 5'd5);
        set_lane(1, op_load, size_word, 12'd8, 32'h0, 5'd6);
        run_pair(1'b0);

        // load and store to one word in the same pair in both orders.
        drive_slot();
        set_lane(0, op_load, size_word, 12'd8, 32'h0, 5'd7);
        set_lane(1, op_store, size_word, 12'd8, 32'h0bad_f00d, 5'd0);
        run_pair(1'b0);
        drive_slot();
        set_lane(0, op_store, size_half, 12'd8, 32'h0000_7777, 5'd0);
        set_lane(1, op_load, size_word, 12'd10, 32'h0, 5'd8);
        run_pair(1'b0);

        // fence squashes a store or an alu op in lane 1.
        drive_slot();
        set_lane(0, op_fence, size_word, 12'd0, 32'h0, 5'd0);
        set_lane(1, op_store, size_word, 12'd16, 32'hcafe_0001, 5'd0);
        run_pair(1'b0);
        drive_slot();
        set_lane(0, op_fence, size_word, 12'd0, 32'h0, 5'd0);
        set_lane(1, op_alu, size_word, 12'd0, 32'h2468_ace0, 5'd9);
        run_pair(1'b0);
        drive_slot();
        set_lane(0, op_load, size_word, 12'd16, 32'h0, 5'd10);
        set_lane(1, op_alu, size_word, 12'd0, 32'h0000_0000, 5'd0);
        run_pair(1'b0);

        for (int i = 0; i < random_pairs; i++) begin
            drive_slot();
            random_lane(0);
            random_lane(1);
            run_pair(1'b0);
        end

        // flush a pair in flight; its store is already in the memory.
        drive_slot();
        set_lane(0, op_load, size_word, 12'd20, 32'h0, 5'd12);
        set_lane(1, op_store, size_word, 12'd20, 32'h600d_600d, 5'd0);
        run_pair(1'b1);
        drive_slot();
        set_lane(0, op_load, size_word, 12'd20, 32'h0, 5'd13);
        set_lane(1, op_alu, size_word, 12'd0, 32'h0f0f_0f0f, 5'd14);
        run_pair(1'b0);

        drive_slot();
        if (DUT.stage.checks.failures == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

/* memory_subsystem.f */
verilog/memory_pkg.sv
verilog/mem_if.sv
verilog/load_store_unit.sv
verilog/memory_stage.sv
verilog/data_memory.sv
verilog/memory_subsystem.sv
verification/memory_subsystem_properties.sv
verification/tb_memory_subsystem.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_memory_subsystem \
    -f memory_subsystem.f

./obj_dir/Vtb_memory_subsystem +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
